//--- project.f
+incdir+verilog
verilog/rs5_exec_pkg.sv
verilog/regbank.sv
verilog/alu.sv
verilog/exec_control.sv
verilog/rs5_exec_top.sv
tests/rs5_exec_asserts.sv
tests/rs5_exec_checker.sv
tests/rs5_exec_tb.sv

//--- run.sh
#!/bin/sh
# Build the execute slice testbench with Verilator, run it and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module rs5_exec_tb \
        -o rs5_exec_sim \
    && ./obj_dir/rs5_exec_sim | tee /dev/stderr | grep -qx "STATUS: PASS" \
    && echo "Simulation passed." \
    || { echo "Simulation failed."; exit 1; }

//--- tests/rs5_exec_tb.sv
/* Testbench top: clock, reset, stimulus table with its driving
 * loop, the checker instance and a watchdog. */

`timescale 1ns/1ps
`default_nettype none

`include "rs5_exec_config.svh"

module rs5_exec_tb;

    localparam int MAX_TESTS = 64;
    localparam int NAME_W    = 96;                      // 12 characters.
    localparam int CLK_NS    = 10;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;        // SUB, SRA.

    logic                   clk;
    logic                   reset_n;
    logic [`RS5_XLEN-1:0]   instr;
    logic                   instr_valid;
    logic                   wb_valid;
    logic                   illegal;
    logic [`RS5_REG_AW-1:0] wb_rd;
    logic [`RS5_XLEN-1:0]   wb_data;

    // Expectations of the test being issued.
    logic [NAME_W-1:0]      exp_name;
    logic                   exp_illegal;
    logic [`RS5_REG_AW-1:0] exp_rd;
    logic [`RS5_XLEN-1:0]   exp_data;

    // Stimulus table.
    logic [NAME_W-1:0]      t_name    [MAX_TESTS];
    logic [`RS5_XLEN-1:0]   t_word    [MAX_TESTS];
    logic                   t_illegal [MAX_TESTS];
    logic [`RS5_REG_AW-1:0] t_rd      [MAX_TESTS];
    logic [`RS5_XLEN-1:0]   t_data    [MAX_TESTS];
    logic                   t_gap     [MAX_TESTS];      // Idle cycle after.
    int                     n_tests;
    logic                   table_ready;

    logic [31:0]            errors;
    logic                   report_done;

    rs5_exec_top rs5_exec_top_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .wb_valid_o    (wb_valid),
        .illegal_o     (illegal),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data)
    );

    rs5_exec_checker #(.NAME_W(NAME_W)) checker_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_valid_i (instr_valid),
        .exp_name_i    (exp_name),
        .exp_illegal_i (exp_illegal),
        .exp_rd_i      (exp_rd),
        .exp_data_i    (exp_data),
        .num_tests_i   (n_tests),
        .wb_valid_i    (wb_valid),
        .illegal_i     (illegal),
        .wb_rd_i       (wb_rd),
        .wb_data_i     (wb_data),
        .errors_o      (errors),
        .done_o        (report_done)
    );

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    // R-type and I-type encodings.
    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input int rs2,
                                               input int rs1, input logic [2:0] f3,
                                               input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `RS5_OPC_OP};
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input int rs1,
                                               input logic [2:0] f3, input int rd);
        return {imm, rs1[4:0], f3, rd[4:0], `RS5_OPC_OPIMM};
    endfunction

    task add_test(input logic [NAME_W-1:0] name, input logic [31:0] word,
                  input logic ill, input logic [31:0] data, input logic gap);
        t_name[n_tests]    = name;
        t_word[n_tests]    = word;
        t_illegal[n_tests] = ill;
        t_rd[n_tests]      = word[11:7];                // rd field of the word.
        t_data[n_tests]    = data;
        t_gap[n_tests]     = gap;
        n_tests++;
    endtask

    // Results worked out by hand; registers are zero after reset.
    task build_table();
        add_test("ADDI_POS",   itype_word(12'h064, 0, 3'b000, 1), 0, 32'h0000_0064, 1);
        add_test("ADDI_NEG",   itype_word(12'hFF9, 0, 3'b000, 2), 0, 32'hFFFF_FFF9, 0);
        add_test("ADDI_MAX",   itype_word(12'h7FF, 0, 3'b000, 3), 0, 32'h0000_07FF, 1);
        add_test("ADDI_MIN",   itype_word(12'h800, 0, 3'b000, 4), 0, 32'hFFFF_F800, 0);
        add_test("ADDI_SH35",  itype_word(12'h023, 0, 3'b000, 5), 0, 32'h0000_0023, 1);
        add_test("ADDI_RST",   itype_word(12'h005, 7, 3'b000, 6), 0, 32'h0000_0005, 1);
        add_test("ADD",        rtype_word(F7_BASE, 2, 1, 3'b000, 8),  0, 32'h0000_005D, 0);
        add_test("SUB",        rtype_word(F7_ALT,  2, 1, 3'b000, 9),  0, 32'h0000_006B, 1);
        add_test("SUB_WRAP",   rtype_word(F7_ALT,  1, 0, 3'b000, 10), 0, 32'hFFFF_FF9C, 0);
        add_test("AND",        rtype_word(F7_BASE, 3, 2, 3'b111, 11), 0, 32'h0000_07F9, 1);
        add_test("OR",         rtype_word(F7_BASE, 4, 1, 3'b110, 12), 0, 32'hFFFF_F864, 0);
        add_test("XOR",        rtype_word(F7_BASE, 3, 2, 3'b100, 13), 0, 32'hFFFF_F806, 1);
        add_test("SLL",        rtype_word(F7_BASE, 5, 1, 3'b001, 14), 0, 32'h0000_0320, 0);
        add_test("SRL",        rtype_word(F7_BASE, 5, 2, 3'b101, 15), 0, 32'h1FFF_FFFF, 1);
        add_test("SRA",        rtype_word(F7_ALT,  5, 4, 3'b101, 16), 0, 32'hFFFF_FF00, 0);
        add_test("SLLI",       itype_word(12'h004, 1, 3'b001, 17), 0, 32'h0000_0640, 1);
        add_test("SRLI",       itype_word(12'h008, 4, 3'b101, 18), 0, 32'h00FF_FFF8, 0);
        add_test("SRAI",       itype_word(12'h408, 4, 3'b101, 19), 0, 32'hFFFF_FFF8, 1);
        add_test("SLT",        rtype_word(F7_BASE, 1, 2, 3'b010, 20), 0, 32'h0000_0001, 0);
        add_test("SLTU",       rtype_word(F7_BASE, 1, 2, 3'b011, 21), 0, 32'h0000_0000, 1);
        add_test("SLTI",       itype_word(12'hFFF, 1, 3'b010, 22), 0, 32'h0000_0000, 0);
        add_test("SLTIU",      itype_word(12'hFFF, 1, 3'b011, 23), 0, 32'h0000_0001, 1);
        add_test("ANDI",       itype_word(12'h0F0, 2, 3'b111, 24), 0, 32'h0000_00F0, 0);
        add_test("X0_WRITE",   itype_word(12'h037, 1, 3'b000, 0),  0, 32'h0000_009B, 1);
        add_test("X0_READ",    rtype_word(F7_BASE, 1, 0, 3'b000, 25), 0, 32'h0000_0064, 1);
        add_test("BAD_OPC",    {20'h12345, 5'd1, 7'b0110111},    1, 32'h0000_0000, 1);
        add_test("BAD_F7_AND", rtype_word(F7_ALT,  3, 2, 3'b111, 8), 1, 32'h0000_0000, 1);
        add_test("KEEP_X8",    itype_word(12'h000, 8, 3'b000, 26), 0, 32'h0000_005D, 1);
        add_test("KEEP_X1",    itype_word(12'h000, 1, 3'b000, 27), 0, 32'h0000_0064, 0);
        add_test("CHAIN0",     itype_word(12'h001, 0, 3'b000, 28), 0, 32'h0000_0001, 0);
        add_test("CHAIN1",     rtype_word(F7_BASE, 28, 28, 3'b000, 28), 0, 32'h0000_0002, 0);
        add_test("CHAIN2",     itype_word(12'h003, 28, 3'b001, 28), 0, 32'h0000_0010, 0);
        add_test("CHAIN3",     rtype_word(F7_ALT,  1, 28, 3'b000, 29), 0, 32'hFFFF_FFAC, 0);
        add_test("CHAIN4",     itype_word(12'h402, 29, 3'b101, 29), 0, 32'hFFFF_FFEB, 0);
        add_test("CHAIN5",     rtype_word(F7_BASE, 2, 29, 3'b100, 30), 0, 32'h0000_0012, 0);
        add_test("CHAIN6",     rtype_word(F7_BASE, 1, 30, 3'b011, 31), 0, 32'h0000_0001, 1);
    endtask

    // Called on a falling edge; returns on the falling edge of the next slot.
    task issue_test(input int k);
        instr       = t_word[k];
        instr_valid = 1'b1;
        exp_name    = t_name[k];
        exp_illegal = t_illegal[k];
        exp_rd      = t_rd[k];
        exp_data    = t_data[k];
        @(negedge clk);
        if (t_gap[k]) begin
            instr_valid = 1'b0;
            instr       = '0;
            @(negedge clk);
        end
    endtask

    initial begin
        reset_n     = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        exp_name    = '0;
        exp_illegal = 1'b0;
        exp_rd      = '0;
        exp_data    = '0;
        n_tests     = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);                      // Reset for 4 cycles.
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        for (int k = 0; k < n_tests; k++) begin
            issue_test(k);
        end
        instr_valid = 1'b0;
        instr       = '0;
        wait (report_done);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Up to 3 cycles per test, plus reset and a margin.
    initial begin
        wait (table_ready);
        #((n_tests * 3 + 4 + 20) * CLK_NS);
        $display("Timeout: the checker did not finish %0d tests in time.", n_tests);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/rs5_exec_checker.sv
/* Checker that compares each writeback report with the values
 * expected for the issued test and prints the result lines. */

`timescale 1ns/1ps
`default_nettype none

`include "rs5_exec_config.svh"

module rs5_exec_checker #(
    parameter int NAME_W = 96                           // Test name, 12 characters.
) (
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    input  wire logic                   instr_valid_i,  // Strobe seen by the DUT.
    input  wire logic [NAME_W-1:0]      exp_name_i,     // Name of the issued test.
    input  wire logic                   exp_illegal_i,  // Expected illegal flag.
    input  wire logic [`RS5_REG_AW-1:0] exp_rd_i,       // Expected reported rd.
    input  wire logic [`RS5_XLEN-1:0]   exp_data_i,     // Expected reported data.
    input  wire logic [31:0]            num_tests_i,    // Tests in the table.
    input  wire logic                   wb_valid_i,
    input  wire logic                   illegal_i,
    input  wire logic [`RS5_REG_AW-1:0] wb_rd_i,
    input  wire logic [`RS5_XLEN-1:0]   wb_data_i,
    output logic      [31:0]            errors_o,       // All failures so far.
    output logic                        done_o          // Counts line printed.
);

    logic                   pending;                    // Report due this cycle.
    logic [NAME_W-1:0]      pend_name;
    logic                   pend_illegal;
    logic [`RS5_REG_AW-1:0] pend_rd;
    logic [`RS5_XLEN-1:0]   pend_data;
    int                     checked = 0;
    int                     passed  = 0;
    int                     errors  = 0;

    assign errors_o = errors;

    initial done_o = 1'b0;

    // Latch what the issued instruction should report.
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pending <= 1'b0;
        end else begin
            pending <= instr_valid_i;
            if (instr_valid_i) begin
                pend_name    <= exp_name_i;
                pend_illegal <= exp_illegal_i;
                pend_rd      <= exp_rd_i;
                pend_data    <= exp_data_i;
            end
        end
    end

    // One line per finished test, first problem found wins.
    task automatic check_report();
        logic bad;
        bad = 1'b1;
        if (!wb_valid_i && !illegal_i) begin
            $display("%0s: no writeback or illegal pulse one cycle after issue.", pend_name);
        end else if (wb_valid_i && illegal_i) begin
            $display("%0s: writeback and illegal pulses came together.", pend_name);
        end else if (pend_illegal && !illegal_i) begin
            $display("%0s: illegal instruction was written back instead of flagged.",
                     pend_name);
        end else if (!pend_illegal && illegal_i) begin
            $display("%0s: legal instruction was flagged as illegal.", pend_name);
        end else if (wb_rd_i != pend_rd) begin
            $display("ERR %0s: rd expected %0d, actual %0d", pend_name, pend_rd, wb_rd_i);
        end else if (wb_data_i != pend_data) begin
            $display("ERR %0s: data expected 32'h%08h, actual 32'h%08h",
                     pend_name, pend_data, wb_data_i);
        end else begin
            $display("OK  %0s: rd %0d data 32'h%08h", pend_name, wb_rd_i, wb_data_i);
            bad = 1'b0;
        end
        if (bad) begin
            errors++;
        end else begin
            passed++;
        end
        checked++;
    endtask

    // Outputs settled since the rising edge, so sample them at the falling one.
    always @(negedge clk) begin
        if (reset_n) begin
            if (pending) begin
                check_report();
                if (checked == num_tests_i) begin
                    $display("Checked %0d tests: %0d passed, %0d errors.",
                             checked, passed, errors);
                    done_o = 1'b1;
                end
            end else if (wb_valid_i || illegal_i) begin
                $display("Report pulse at %0t with no instruction issued.", $time);
                errors++;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/rs5_exec_asserts.sv
/* Concurrent checks on the writeback and illegal pulses,
 * bound into the execute slice top level. */

`timescale 1ns/1ps
`default_nettype none

module rs5_exec_asserts (
    input wire logic clk,
    input wire logic reset_n,
    input wire logic instr_valid_i,     // Issue strobe.
    input wire logic wb_valid_i,        // Writeback pulse.
    input wire logic illegal_i          // Illegal pulse.
);

    // A report is either a writeback or an illegal flag, never both.
    assert property (@(posedge clk) disable iff (!reset_n)
        !(wb_valid_i && illegal_i))
        else $error("Writeback and illegal pulses are high in the same cycle.");

    // Both report pulses stay low while reset is held.
    assert property (@(posedge clk) !reset_n |-> (!wb_valid_i && !illegal_i))
        else $error("Report pulse seen during reset.");

    // Every strobe gets exactly one report on the next cycle.
    assert property (@(posedge clk) disable iff (!reset_n)
        instr_valid_i |=> (wb_valid_i || illegal_i))
        else $error("No report one cycle after an issue strobe.");

    // And no report appears without a strobe one cycle before.
    assert property (@(posedge clk) disable iff (!reset_n)
        (wb_valid_i || illegal_i) |-> $past(instr_valid_i))
        else $error("Report pulse without an issue strobe in the previous cycle.");

endmodule

bind rs5_exec_top rs5_exec_asserts asserts_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .instr_valid_i (instr_valid_i),
    .wb_valid_i    (wb_valid_o),
    .illegal_i     (illegal_o)
);

`default_nettype wire

//--- verilog/rs5_exec_top.sv
/* Execute slice top level: control, register bank and ALU
 * connected by wires. */

`timescale 1ns/1ps
`default_nettype none

`include "rs5_exec_config.svh"

module rs5_exec_top (
    input  wire logic                   clk,
    input  wire logic                   reset_n,

    input  wire logic [`RS5_XLEN-1:0]   instr_i,        // Raw instruction word.
    input  wire logic                   instr_valid_i,  // Issue strobe.

    output logic                        wb_valid_o,     // Writeback report valid.
    output logic                        illegal_o,      // Illegal instruction.
    output logic      [`RS5_REG_AW-1:0] wb_rd_o,        // Written register.
    output logic      [`RS5_XLEN-1:0]   wb_data_o       // Written value.
);

    import rs5_exec_pkg::*;

    instr_u                 instr_w;                    // Word as union.
    logic [`RS5_REG_AW-1:0] rs1_w;
    logic [`RS5_REG_AW-1:0] rs2_w;
    logic [`RS5_REG_AW-1:0] rd_w;
    logic                   we_w;
    alu_op_e                alu_op_w;
    logic                   use_imm_w;
    logic [`RS5_XLEN-1:0]   imm_w;
    logic [`RS5_XLEN-1:0]   rs1_data_w;
    logic [`RS5_XLEN-1:0]   rs2_data_w;
    logic [`RS5_XLEN-1:0]   result_w;                   // To bank and report.

    assign instr_w = instr_i;

    exec_control exec_control_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_i       (instr_w),
        .instr_valid_i (instr_valid_i),
        .rs1_o         (rs1_w),
        .rs2_o         (rs2_w),
        .rd_o          (rd_w),
        .we_o          (we_w),
        .alu_op_o      (alu_op_w),
        .use_imm_o     (use_imm_w),
        .imm_o         (imm_w),
        .alu_result_i  (result_w),
        .wb_valid_o    (wb_valid_o),
        .illegal_o     (illegal_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    regbank regbank_i (
        .clk     (clk),
        .reset_n (reset_n),
        .rs1_i   (rs1_w),
        .rs2_i   (rs2_w),
        .rd_i    (rd_w),
        .we_i    (we_w),
        .data_i  (result_w),
        .data1_o (rs1_data_w),
        .data2_o (rs2_data_w)
    );

    alu alu_i (
        .op_a_i     (rs1_data_w),
        .rs2_data_i (rs2_data_w),
        .imm_i      (imm_w),
        .use_imm_i  (use_imm_w),
        .op_i       (alu_op_w),
        .result_o   (result_w)
    );

endmodule

`default_nettype wire

//--- verilog/exec_control.sv
/* Decoder for the OP and OP-IMM groups plus the writeback
 * sequencer that issues the register write and the report. */

`timescale 1ns/1ps
`default_nettype none

`include "rs5_exec_config.svh"

module exec_control (
    input  wire logic                     clk,
    input  wire logic                     reset_n,

    input  wire rs5_exec_pkg::instr_u     instr_i,        // Instruction word.
    input  wire logic                     instr_valid_i,  // One-cycle strobe.

    output logic      [`RS5_REG_AW-1:0]   rs1_o,          // Source 1 index.
    output logic      [`RS5_REG_AW-1:0]   rs2_o,          // Source 2 index.
    output logic      [`RS5_REG_AW-1:0]   rd_o,           // Destination index.
    output logic                          we_o,           // Register write.

    output rs5_exec_pkg::alu_op_e         alu_op_o,       // ALU operation.
    output logic                          use_imm_o,      // Immediate operand.
    output logic      [`RS5_XLEN-1:0]     imm_o,          // Sign-extended imm.
    input  wire logic [`RS5_XLEN-1:0]     alu_result_i,   // ALU result.

    output logic                          wb_valid_o,     // Writeback pulse.
    output logic                          illegal_o,      // Illegal pulse.
    output logic      [`RS5_REG_AW-1:0]   wb_rd_o,        // Reported rd.
    output logic      [`RS5_XLEN-1:0]     wb_data_o       // Reported data.
);

    import rs5_exec_pkg::*;

    localparam logic [6:0] F7_BASE = 7'b0000000;  // Plain variant.
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA variant.

    logic [6:0] opcode;                           // Shared by both views.
    logic [2:0] funct3;
    logic [6:0] funct7;                           // Same bits as imm[11:5].
    logic       legal;                            // Decoded a supported op.

    // Fields at the same place in both formats.
    assign opcode = instr_i.r.opcode;
    assign funct3 = instr_i.r.funct3;
    assign rs1_o  = instr_i.r.rs1;
    assign rs2_o  = instr_i.r.rs2;
    assign rd_o   = instr_i.r.rd;

    // Immediate view; only meaningful for OP-IMM.
    assign imm_o  = {{(`RS5_XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};

    // Shift immediates carry their funct7 in the top immediate bits.
    assign funct7 = instr_i.r.funct7;

    always_comb begin
        alu_op_o  = ALU_ADD;                      // Harmless default.
        use_imm_o = 1'b0;
        legal     = 1'b0;
        if (opcode == `RS5_OPC_OP || opcode == `RS5_OPC_OPIMM) begin
            use_imm_o = (opcode == `RS5_OPC_OPIMM);
            case (funct3)
                3'b000: begin
                    if (use_imm_o) begin
                        legal = 1'b1;             // ADDI has no funct7.
                    end else if (funct7 == F7_BASE) begin
                        legal = 1'b1;
                    end else if (funct7 == F7_ALT) begin
                        alu_op_o = ALU_SUB;       // Register form only.
                        legal    = 1'b1;
                    end
                end
                3'b001: begin
                    alu_op_o = ALU_SLL;
                    legal    = (funct7 == F7_BASE);
                end
                3'b010: begin
                    alu_op_o = ALU_SLT;
                    legal    = use_imm_o || (funct7 == F7_BASE);
                end
                3'b011: begin
                    alu_op_o = ALU_SLTU;
                    legal    = use_imm_o || (funct7 == F7_BASE);
                end
                3'b100: begin
                    alu_op_o = ALU_XOR;
                    legal    = use_imm_o || (funct7 == F7_BASE);
                end
                3'b101: begin
                    if (funct7 == F7_BASE) begin
                        alu_op_o = ALU_SRL;
                        legal    = 1'b1;
                    end else if (funct7 == F7_ALT) begin
                        alu_op_o = ALU_SRA;       // Both forms allow SRA.
                        legal    = 1'b1;
                    end
                end
                3'b110: begin
                    alu_op_o = ALU_OR;
                    legal    = use_imm_o || (funct7 == F7_BASE);
                end
                default: begin
                    alu_op_o = ALU_AND;           // funct3 111.
                    legal    = use_imm_o || (funct7 == F7_BASE);
                end
            endcase
        end
    end

    // Write only for a legal strobed instruction; rd == 0 is the bank's job.
    assign we_o = instr_valid_i && legal;

    // Report registers, one cycle behind the issuing edge.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_valid_o <= 1'b0;
            illegal_o  <= 1'b0;
            wb_rd_o    <= '0;
            wb_data_o  <= '0;
        end else begin
            wb_valid_o <= instr_valid_i && legal;
            illegal_o  <= instr_valid_i && !legal;
            if (instr_valid_i) begin
                wb_rd_o   <= rd_o;
                wb_data_o <= legal ? alu_result_i : '0; // Zero on illegal.
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/alu.sv
/* Integer ALU with register or immediate second operand,
 * covering add/sub, logic ops, shifts and set-less-than. */

`timescale 1ns/1ps
`default_nettype none

`include "rs5_exec_config.svh"

module alu (
    input  wire logic [`RS5_XLEN-1:0] op_a_i,       // First operand, rs1.
    input  wire logic [`RS5_XLEN-1:0] rs2_data_i,   // Register second operand.
    input  wire logic [`RS5_XLEN-1:0] imm_i,        // Sign-extended immediate.
    input  wire logic                 use_imm_i,    // Take immediate as operand B.
    input  wire rs5_exec_pkg::alu_op_e op_i,        // Operation.
    output logic      [`RS5_XLEN-1:0] result_o      // Result.
);

    import rs5_exec_pkg::*;

    localparam int SHW = $clog2(`RS5_XLEN);         // Shift amount width.

    logic [`RS5_XLEN-1:0] op_b;                     // Selected second operand.
    logic [SHW-1:0]       shamt;                    // Low bits of operand B.
    logic                 lt_s;                     // Signed less-than.
    logic                 lt_u;                     // Unsigned less-than.

    assign op_b  = use_imm_i ? imm_i : rs2_data_i;
    assign shamt = op_b[SHW-1:0];                   // Upper bits ignored.
    assign lt_s  = $signed(op_a_i) < $signed(op_b);
    assign lt_u  = op_a_i < op_b;

    always_comb begin
        unique case (op_i)
            ALU_ADD:  result_o = op_a_i + op_b;
            ALU_SUB:  result_o = op_a_i - op_b;     // Wraps modulo 2^XLEN.
            ALU_AND:  result_o = op_a_i & op_b;
            ALU_OR:   result_o = op_a_i | op_b;
            ALU_XOR:  result_o = op_a_i ^ op_b;
            ALU_SLL:  result_o = op_a_i << shamt;
            ALU_SRL:  result_o = op_a_i >> shamt;
            ALU_SRA:  result_o = $unsigned($signed(op_a_i) >>> shamt); // Sign fill.
            ALU_SLT:  result_o = {{(`RS5_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result_o = {{(`RS5_XLEN-1){1'b0}}, lt_u};
            default:  result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/regbank.sv
/* Register bank: 31 writable registers, x0 tied to zero,
 * two combinational read ports and one clocked write port. */

`timescale 1ns/1ps
`default_nettype none

`include "rs5_exec_config.svh"

module regbank (
    input  wire logic                   clk,
    input  wire logic                   reset_n,

    input  wire logic [`RS5_REG_AW-1:0] rs1_i,      // Read port 1 index.
    input  wire logic [`RS5_REG_AW-1:0] rs2_i,      // Read port 2 index.
    input  wire logic [`RS5_REG_AW-1:0] rd_i,       // Write index.
    input  wire logic                   we_i,       // Write enable.
    input  wire logic [`RS5_XLEN-1:0]   data_i,     // Write data.
    output logic      [`RS5_XLEN-1:0]   data1_o,    // Read port 1 data.
    output logic      [`RS5_XLEN-1:0]   data2_o     // Read port 2 data.
);

    // Storage for x1 upward; x0 has no flops.
    logic [`RS5_XLEN-1:0] regfile [`RS5_NREGS-1:1];

    // Reads are combinational, x0 forced to zero.
    assign data1_o = (rs1_i == '0) ? '0 : regfile[rs1_i];
    assign data2_o = (rs2_i == '0) ? '0 : regfile[rs2_i];

    // Write lands at the issuing edge so the next cycle sees it.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < `RS5_NREGS; i++) begin
                regfile[i] <= '0;               // All registers start at zero.
            end
        end else if (we_i && rd_i != '0) begin
            regfile[rd_i] <= data_i;            // Writes to x0 are dropped here.
        end
    end

endmodule

`default_nettype wire

//--- verilog/rs5_exec_pkg.sv
/* Instruction format structs, the two-view
 * instruction union and the ALU operation enum. */

`default_nettype none

`include "rs5_exec_config.svh"

package rs5_exec_pkg;

    // Register-register format.
    typedef struct packed {
        logic [6:0]             funct7;     // Operation variant.
        logic [`RS5_REG_AW-1:0] rs2;        // Second source.
        logic [`RS5_REG_AW-1:0] rs1;        // First source.
        logic [2:0]             funct3;     // Operation select.
        logic [`RS5_REG_AW-1:0] rd;         // Destination.
        logic [6:0]             opcode;     // Major opcode.
    } r_type_t;

    // Register-immediate format.
    typedef struct packed {
        logic [11:0]            imm;        // Signed immediate.
        logic [`RS5_REG_AW-1:0] rs1;        // Source.
        logic [2:0]             funct3;     // Operation select.
        logic [`RS5_REG_AW-1:0] rd;         // Destination.
        logic [6:0]             opcode;     // Major opcode.
    } i_type_t;

    // One instruction word seen through either format.
    typedef union packed {
        r_type_t r;                         // View used for OP.
        i_type_t i;                         // View used for OP-IMM.
    } instr_u;

    // ALU operations.
    typedef enum logic [3:0] {
        ALU_ADD,                            // Sum.
        ALU_SUB,                            // Difference, wraps.
        ALU_AND,                            // Bitwise and.
        ALU_OR,                             // Bitwise or.
        ALU_XOR,                            // Bitwise xor.
        ALU_SLL,                            // Left shift.
        ALU_SRL,                            // Logical right shift.
        ALU_SRA,                            // Arithmetic right shift.
        ALU_SLT,                            // Signed compare.
        ALU_SLTU                            // Unsigned compare.
    } alu_op_e;

endpackage

`default_nettype wire

//--- verilog/rs5_exec_config.svh
/* Width, register count and opcode macros
 * shared by the execute slice. */

`ifndef RS5_EXEC_CONFIG_SVH
`define RS5_EXEC_CONFIG_SVH

// Datapath and register file geometry.
`define RS5_XLEN    32                  // Data width.
`define RS5_NREGS   32                  // Architectural registers, x0 included.
`define RS5_REG_AW  5                   // Register index width.

// Major opcodes of the two supported groups.
`define RS5_OPC_OP     7'b0110011       // Register-register.
`define RS5_OPC_OPIMM  7'b0010011       // Register-immediate.

`endif
